/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim.f \
  --top-module tb_mem_subsystem \
  -o tb_mem_subsystem

./obj_dir/tb_mem_subsystem | tee sim.log

if grep -q '>>> FAIL' sim.log; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"

/* sim.f */
+incdir+verilog
verilog/tl_pkg.sv
verilog/tl_fifo.sv
verilog/tl_arbiter_n1.sv
verilog/tl_socket_1n.sv
verilog/tl_adapter_bram.sv
verilog/mem_subsystem.sv
test/tl_assertions.sv
test/tb_mem_subsystem.sv

/* test/tb_mem_subsystem.sv */
// **************************************************
// Random two-host traffic against BRAM models
// Source ids are reused only after their response
// **************************************************
`timescale 1ns/1ps
`include "tl_macros.svh"

module tb_mem_subsystem import tl_pkg::*; ();

  localparam int NUM_REQ     = 150;
  localparam int TIMEOUT_CYC = 2 * NUM_REQ * 20;
  // Just above the IO window, so decode sees close neighbours
  localparam logic [31:0] MEM_BASE = 32'h8001_0040;

  logic        clk;
  logic        rst_n;
  logic [1:0]  host_a_valid;
  tl_a_t [1:0] host_a;
  logic [1:0]  host_a_ready;
  logic [1:0]  host_d_valid;
  tl_d_t [1:0] host_d;
  logic [1:0]  host_d_ready;

  logic        mem_en;
  logic        mem_we;
  logic [28:0] mem_addr;
  logic [7:0]  mem_wmask;
  logic [63:0] mem_wdata;
  logic [63:0] mem_rdata;
  logic        io_en;
  logic        io_we;
  logic [28:0] io_addr;
  logic [7:0]  io_wmask;
  logic [63:0] io_wdata;
  logic [63:0] io_rdata;

  // BRAM contents, keyed by window bit and word address
  logic [63:0] bram_words [logic [29:0]];
  logic [63:0] ref_words  [logic [29:0]];

  // Scoreboard per host and source id
  logic        busy     [2][8];
  logic        seen     [2][8];
  logic        idle_req [2][8];
  tl_d_op_e    exp_op   [2][8];
  logic [63:0] exp_data [2][8];
  int          xfer_cyc [2][8];
  int          sent     [2];
  int          streak   [2];
  int          outstanding;
  int          cycle;
  int          errors;
  int          checks;
  int unsigned seed;

  mem_subsystem dut_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .host_a_valid_i (host_a_valid),
    .host_a_i       (host_a),
    .host_a_ready_o (host_a_ready),
    .host_d_valid_o (host_d_valid),
    .host_d_o       (host_d),
    .host_d_ready_i (host_d_ready),
    .mem_en_o       (mem_en),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wmask_o    (mem_wmask),
    .mem_wdata_o    (mem_wdata),
    .mem_rdata_i    (mem_rdata),
    .io_en_o        (io_en),
    .io_we_o        (io_we),
    .io_addr_o      (io_addr),
    .io_wmask_o     (io_wmask),
    .io_wdata_o     (io_wdata),
    .io_rdata_i     (io_rdata)
  );

  always #4 clk = ~clk;

  // Unwritten words read back as a pattern of their address
  function automatic logic [63:0] fill_word(input logic [28:0] waddr);
    return {3'b000, waddr, 3'b111, ~waddr};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                              input logic [63:0] new_w,
                                              input logic [7:0]  mask);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++)
    begin
      if (mask[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  // Window mask covers contiguous low bits
  function automatic logic in_io_window(input logic [31:0] addr);
    return (addr >= `IO_BASE) && (addr <= (`IO_BASE | `IO_MASK));
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    checks++;
    if (exp_v !== act_v)
    begin
      errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // BRAM models, read data one cycle after en
  always @(posedge clk)
  begin
    if (mem_en)
    begin
      if (!bram_words.exists({1'b0, mem_addr}))
        bram_words[{1'b0, mem_addr}] = fill_word(mem_addr);
      mem_rdata <= bram_words[{1'b0, mem_addr}];
      if (mem_we)
        bram_words[{1'b0, mem_addr}] =
          merge_bytes(bram_words[{1'b0, mem_addr}], mem_wdata, mem_wmask);
    end
    if (io_en)
    begin
      if (!bram_words.exists({1'b1, io_addr}))
        bram_words[{1'b1, io_addr}] = fill_word(io_addr);
      io_rdata <= bram_words[{1'b1, io_addr}];
      if (io_we)
        bram_words[{1'b1, io_addr}] =
          merge_bytes(bram_words[{1'b1, io_addr}], io_wdata, io_wmask);
    end
  end

  always @(posedge clk)
  begin : traffic
    tl_a_t       req;
    tl_d_t       rsp;
    logic        io;
    logic        oth;
    logic [28:0] waddr;
    logic [29:0] key;
    logic [2:0]  src;
    logic [2:0]  start;
    logic [2:0]  cand;
    logic        found;
    logic [7:0]  exp_mask;
    logic        p_we;
    logic [28:0] p_addr;
    logic [7:0]  p_mask;
    logic [63:0] p_wdata;
    string       pfx;
    int          xfers;
    if (rst_n)
    begin
      cycle++;
      xfers = 0;
      for (int h = 0; h < 2; h++)
      begin
        oth = (h == 0);
        if (host_a_valid[h] && host_a_ready[h])
        begin
          req   = host_a[h];
          io    = in_io_window(req.address);
          waddr = req.address[31:3];
          key   = {io, waddr};
          src   = req.source[2:0];
          xfers++;
          if (io)
          begin
            pfx = "io_";
            p_we = io_we;
            p_addr = io_addr;
            p_mask = io_wmask;
            p_wdata = io_wdata;
          end
          else
          begin
            pfx = "mem_";
            p_we = mem_we;
            p_addr = mem_addr;
            p_mask = mem_wmask;
            p_wdata = mem_wdata;
          end
          check_val("io_en_o", 64'(io), 64'(io_en));
          check_val("mem_en_o", 64'(!io), 64'(mem_en));
          check_val({pfx, "addr_o"}, 64'(waddr), 64'(p_addr));
          check_val({pfx, "we_o"}, 64'(req.opcode != Get), 64'(p_we));
          if (!ref_words.exists(key))
            ref_words[key] = fill_word(waddr);
          if (req.opcode == Get)
          begin
            exp_op[h][src]   = AccessAckData;
            exp_data[h][src] = ref_words[key];
          end
          else
          begin
            exp_mask = (req.opcode == PutFullData) ? 8'hff : req.mask;
            check_val({pfx, "wmask_o"}, 64'(exp_mask), 64'(p_mask));
            check_val({pfx, "wdata_o"}, req.data, p_wdata);
            ref_words[key] = merge_bytes(ref_words[key], req.data, exp_mask);
            exp_op[h][src]   = AccessAck;
            exp_data[h][src] = 64'h0;
          end
          busy[h][src]     = 1'b1;
          seen[h][src]     = 1'b0;
          idle_req[h][src] = (outstanding == 0);
          xfer_cyc[h][src] = cycle;
          outstanding++;
          sent[h]++;
          // Grants only count as a run while the other host waits
          streak[oth] = 0;
          if (host_a_valid[oth])
            streak[h]++;
          else
            streak[h] = 0;
          if (streak[h] > 2)
            flag_error($sformatf("host %0d granted more than twice in a row", h));
        end
      end
      if (xfers > 1)
        flag_error("both hosts transferred on A in the same cycle");
      if (xfers == 0)
      begin
        check_val("mem_en_o", 64'h0, 64'(mem_en));
        check_val("io_en_o", 64'h0, 64'(io_en));
      end

      for (int h = 0; h < 2; h++)
      begin
        rsp = host_d[h];
        src = rsp.source[2:0];
        if (host_d_valid[h] && !busy[h][src])
        begin
          flag_error($sformatf("host %0d response for source %0d, none outstanding",
                               h, src));
        end
        else if (host_d_valid[h])
        begin
          if (!seen[h][src] && idle_req[h][src])
            check_val("d latency", 64'd2, 64'(cycle - xfer_cyc[h][src]));
          seen[h][src] = 1'b1;
          if (host_d_ready[h])
          begin
            check_val("host_d_o.source[3]", 64'h0, 64'(rsp.source[3]));
            check_val("host_d_o.opcode", 64'(exp_op[h][src]), 64'(rsp.opcode));
            if (exp_op[h][src] == AccessAckData)
              check_val("host_d_o.data", exp_data[h][src], rsp.data);
            busy[h][src] = 1'b0;
            outstanding--;
          end
        end
      end

      for (int h = 0; h < 2; h++)
      begin
        host_d_ready[h] <= (($urandom % 4) != 0);
        if (!host_a_valid[h] || host_a_ready[h])
        begin
          host_a_valid[h] <= 1'b0;
          found = 1'b0;
          src   = 3'd0;
          start = 3'($urandom);
          for (int i = 0; i < 8; i++)
          begin
            cand = start + 3'(i);
            if (!found && !busy[h][cand])
            begin
              found = 1'b1;
              src   = cand;
            end
          end
          if (found && sent[h] < NUM_REQ && (($urandom % 4) != 0))
          begin
            case ($urandom % 3)
              0: req.opcode = PutFullData;
              1: req.opcode = PutPartialData;
              default: req.opcode = Get;
            endcase
            if (($urandom % 2) == 0)
              req.address = `IO_BASE + 32'(($urandom % 8) * 8);
            else
              req.address = MEM_BASE + 32'(($urandom % 16) * 8);
            req.address[2:0] = 3'($urandom);
            req.mask   = 8'($urandom);
            req.data   = {$urandom, $urandom};
            req.source = {1'b0, src};
            host_a[h]       <= req;
            host_a_valid[h] <= 1'b1;
          end
        end
      end
    end
  end

  initial
  begin
    seed         = $urandom(32'h9e);
    clk          = 1'b0;
    rst_n        = 1'b0;
    host_a_valid = '0;
    host_a       = '0;
    host_d_ready = '0;
    mem_rdata    = '0;
    io_rdata     = '0;
    busy         = '{default: 1'b0};
    seen         = '{default: 1'b0};
    idle_req     = '{default: 1'b0};
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    while (!(sent[0] == NUM_REQ && sent[1] == NUM_REQ && outstanding == 0)
           && cycle < TIMEOUT_CYC)
      @(negedge clk);
    if (cycle >= TIMEOUT_CYC)
      flag_error("timeout, not every request completed in time");
    if (outstanding != 0)
      flag_error($sformatf("%0d responses never arrived", outstanding));
    $display("Checks %0d, errors %0d, requests %0d, cycles %0d",
             checks, errors, sent[0] + sent[1], cycle);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* test/tl_assertions.sv */
// **************************************************
// Handshake rules at the top level ports
// **************************************************
`timescale 1ns/1ps

module tl_assertions import tl_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic [1:0]  host_a_valid_i,
  input tl_a_t [1:0] host_a_i,
  input logic [1:0]  host_a_ready_o,
  input logic [1:0]  host_d_valid_o,
  input logic [1:0]  host_d_ready_i,
  input logic        mem_en_o,
  input logic        mem_we_o,
  input logic        io_en_o,
  input logic        io_we_o
);

  for (genvar h = 0; h < 2; h++)
  begin : g_host
    a_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (host_a_valid_i[h] && !host_a_ready_o[h])
      |=> (host_a_valid_i[h] && $stable(host_a_i[h])))
      else $error("host %0d A channel changed before ready", h);

    d_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (host_d_valid_o[h] && !host_d_ready_i[h]) |=> host_d_valid_o[h])
      else $error("host %0d D valid dropped before ready", h);
  end

  mem_we_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_we_o |-> mem_en_o)
    else $error("mem write enable without enable");

  io_we_en: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    io_we_o |-> io_en_o)
    else $error("io write enable without enable");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> ((host_d_valid_o == 2'b00) && !mem_en_o && !io_en_o))
    else $error("valid output high during reset");

endmodule

bind mem_subsystem tl_assertions u_tl_assertions (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .host_a_valid_i (host_a_valid_i),
  .host_a_i       (host_a_i),
  .host_a_ready_o (host_a_ready_o),
  .host_d_valid_o (host_d_valid_o),
  .host_d_ready_i (host_d_ready_i),
  .mem_en_o       (mem_en_o),
  .mem_we_o       (mem_we_o),
  .io_en_o        (io_en_o),
  .io_we_o        (io_we_o)
);

/* verilog/mem_subsystem.sv */
// **************************************************
// Two TL-UL hosts onto a memory and an IO BRAM port
// Idle path answers two cycles after the A transfer
// **************************************************
`timescale 1ns/1ps
`include "tl_macros.svh"

module mem_subsystem import tl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  logic [1:0]                host_a_valid_i,
  input  tl_a_t [1:0]               host_a_i,
  output logic [1:0]                host_a_ready_o,
  output logic [1:0]                host_d_valid_o,
  output tl_d_t [1:0]               host_d_o,
  input  logic [1:0]                host_d_ready_i,

  output logic                      mem_en_o,
  output logic                      mem_we_o,
  output logic [`BRAM_ADDR_W-1:0]   mem_addr_o,
  output logic [`TL_MASK_W-1:0]     mem_wmask_o,
  output logic [`TL_DATA_W-1:0]     mem_wdata_o,
  input  logic [`TL_DATA_W-1:0]     mem_rdata_i,

  output logic                      io_en_o,
  output logic                      io_we_o,
  output logic [`BRAM_ADDR_W-1:0]   io_addr_o,
  output logic [`TL_MASK_W-1:0]     io_wmask_o,
  output logic [`TL_DATA_W-1:0]     io_wdata_o,
  input  logic [`TL_DATA_W-1:0]     io_rdata_i
);

  // Shared bus between arbiter and socket
  logic  bus_a_valid;
  tl_a_t bus_a;
  logic  bus_a_ready;
  logic  bus_d_valid;
  tl_d_t bus_d;
  logic  bus_d_ready;

  logic  mem_a_valid;
  tl_a_t mem_a;
  logic  mem_a_ready;
  logic  mem_d_valid;
  tl_d_t mem_d;
  logic  mem_d_ready;

  logic  io_a_valid;
  tl_a_t io_a;
  logic  io_a_ready;
  logic  io_d_valid;
  tl_d_t io_d;
  logic  io_d_ready;

  tl_arbiter_n1 u_arb (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .host_a_valid_i (host_a_valid_i),
    .host_a_i       (host_a_i),
    .host_a_ready_o (host_a_ready_o),
    .host_d_valid_o (host_d_valid_o),
    .host_d_o       (host_d_o),
    .host_d_ready_i (host_d_ready_i),
    .dev_a_valid_o  (bus_a_valid),
    .dev_a_o        (bus_a),
    .dev_a_ready_i  (bus_a_ready),
    .dev_d_valid_i  (bus_d_valid),
    .dev_d_i        (bus_d),
    .dev_d_ready_o  (bus_d_ready)
  );

  tl_socket_1n u_socket (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .host_a_valid_i (bus_a_valid),
    .host_a_i       (bus_a),
    .host_a_ready_o (bus_a_ready),
    .host_d_valid_o (bus_d_valid),
    .host_d_o       (bus_d),
    .host_d_ready_i (bus_d_ready),
    .mem_a_valid_o  (mem_a_valid),
    .mem_a_o        (mem_a),
    .mem_a_ready_i  (mem_a_ready),
    .mem_d_valid_i  (mem_d_valid),
    .mem_d_i        (mem_d),
    .mem_d_ready_o  (mem_d_ready),
    .io_a_valid_o   (io_a_valid),
    .io_a_o         (io_a),
    .io_a_ready_i   (io_a_ready),
    .io_d_valid_i   (io_d_valid),
    .io_d_i         (io_d),
    .io_d_ready_o   (io_d_ready)
  );

  tl_adapter_bram u_mem_bram (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .a_valid_i    (mem_a_valid),
    .a_i          (mem_a),
    .a_ready_o    (mem_a_ready),
    .d_valid_o    (mem_d_valid),
    .d_o          (mem_d),
    .d_ready_i    (mem_d_ready),
    .bram_en_o    (mem_en_o),
    .bram_we_o    (mem_we_o),
    .bram_addr_o  (mem_addr_o),
    .bram_wmask_o (mem_wmask_o),
    .bram_wdata_o (mem_wdata_o),
    .bram_rdata_i (mem_rdata_i)
  );

  tl_adapter_bram u_io_bram (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .a_valid_i    (io_a_valid),
    .a_i          (io_a),
    .a_ready_o    (io_a_ready),
    .d_valid_o    (io_d_valid),
    .d_o          (io_d),
    .d_ready_i    (io_d_ready),
    .bram_en_o    (io_en_o),
    .bram_we_o    (io_we_o),
    .bram_addr_o  (io_addr_o),
    .bram_wmask_o (io_wmask_o),
    .bram_wdata_o (io_wdata_o),
    .bram_rdata_i (io_rdata_i)
  );

endmodule

/* verilog/tl_adapter_bram.sv */
// **************************************************
// BRAM read data must arrive one cycle after en
// At most two responses outstanding
// **************************************************
`timescale 1ns/1ps
`include "tl_macros.svh"

module tl_adapter_bram import tl_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  logic                      a_valid_i,
  input  tl_a_t                     a_i,
  output logic                      a_ready_o,
  output logic                      d_valid_o,
  output tl_d_t                     d_o,
  input  logic                      d_ready_i,

  output logic                      bram_en_o,
  output logic                      bram_we_o,
  output logic [`BRAM_ADDR_W-1:0]   bram_addr_o,
  output logic [`TL_MASK_W-1:0]     bram_wmask_o,
  output logic [`TL_DATA_W-1:0]     bram_wdata_o,
  input  logic [`TL_DATA_W-1:0]     bram_rdata_i
);

  localparam int FIFO_DEPTH = 2;

  logic                       pending_q;
  tl_d_op_e                   d_op_q;
  logic [`TL_SRC_W-1:0]       src_q;
  logic [1:0]                 fifo_count;
  logic [2:0]                 used_slots;
  tl_d_t                      d_new;

  // Count the access in flight as taken
  assign used_slots = {1'b0, fifo_count} + {2'b0, pending_q};
  assign a_ready_o  = (used_slots < 3'(FIFO_DEPTH));

  assign bram_en_o    = a_valid_i & a_ready_o;
  assign bram_we_o    = bram_en_o & (a_i.opcode != Get);
  assign bram_addr_o  = a_i.address[`TL_ADDR_W-1 -: `BRAM_ADDR_W];
  assign bram_wdata_o = a_i.data;
  assign bram_wmask_o = (a_i.opcode == PutFullData)    ? '1 :
                        (a_i.opcode == PutPartialData) ? a_i.mask : '0;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pending_q <= 1'b0;
    end
    else
    begin
      pending_q <= bram_en_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bram_en_o)
    begin
      d_op_q <= (a_i.opcode == Get) ? AccessAckData : AccessAck;
      src_q  <= a_i.source;
    end
  end

  assign d_new.opcode = d_op_q;
  assign d_new.data   = (d_op_q == AccessAckData) ? bram_rdata_i : '0;
  assign d_new.source = src_q;

  tl_fifo #(
    .payload_t (tl_d_t),
    .DEPTH     (FIFO_DEPTH)
  ) u_d_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (pending_q),
    .in_ready_o  (),
    .in_i        (d_new),
    .out_valid_o (d_valid_o),
    .out_ready_i (d_ready_i),
    .out_o       (d_o),
    .count_o     (fifo_count)
  );

endmodule

/* verilog/tl_arbiter_n1.sv */
// **************************************************
// Two hosts onto one link, combinational on A and D
// Host source ids must keep their top bit at zero
// **************************************************
`timescale 1ns/1ps
`include "tl_macros.svh"

module tl_arbiter_n1 import tl_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,

  input  logic [1:0]    host_a_valid_i,
  input  tl_a_t [1:0]   host_a_i,
  output logic [1:0]    host_a_ready_o,
  output logic [1:0]    host_d_valid_o,
  output tl_d_t [1:0]   host_d_o,
  input  logic [1:0]    host_d_ready_i,

  output logic          dev_a_valid_o,
  output tl_a_t         dev_a_o,
  input  logic          dev_a_ready_i,
  input  logic          dev_d_valid_i,
  input  tl_d_t         dev_d_i,
  output logic          dev_d_ready_o
);

  logic  lock_q;
  logic  lock_idx_q;
  logic  prio_q;
  logic  sel;
  logic  d_dst;
  tl_d_t d_stripped;

  // A stalled grant holds until it transfers
  always_comb
  begin
    if (lock_q)
    begin
      sel = lock_idx_q;
    end
    else if (&host_a_valid_i)
    begin
      sel = prio_q;
    end
    else
    begin
      sel = host_a_valid_i[1];
    end
  end

  always_comb
  begin
    dev_a_valid_o       = host_a_valid_i[sel];
    dev_a_o             = host_a_i[sel];
    dev_a_o.source      = {sel, host_a_i[sel].source[`TL_HOST_SRC_W-1:0]};
    host_a_ready_o      = '0;
    host_a_ready_o[sel] = dev_a_ready_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
      prio_q     <= 1'b0;
    end
    else if (dev_a_valid_o)
    begin
      if (dev_a_ready_i)
      begin
        lock_q <= 1'b0;
        // Other host wins the next tie
        prio_q <= ~sel;
      end
      else
      begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel;
      end
    end
  end

  // Responses go back by the host bit, which is then cleared
  assign d_dst = dev_d_i.source[`TL_SRC_W-1];

  always_comb
  begin
    d_stripped                       = dev_d_i;
    d_stripped.source[`TL_SRC_W-1]   = 1'b0;
  end

  assign host_d_valid_o[0] = dev_d_valid_i & ~d_dst;
  assign host_d_valid_o[1] = dev_d_valid_i & d_dst;
  assign host_d_o[0]       = d_stripped;
  assign host_d_o[1]       = d_stripped;
  assign dev_d_ready_o     = host_d_ready_i[d_dst];

endmodule

/* verilog/tl_fifo.sv */
// **************************************************
// Registered FIFO, output valid one edge after push
// DEPTH of at least 2
// **************************************************
`timescale 1ns/1ps

module tl_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  payload_t                     in_i,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output payload_t                     out_o,
  output logic [$clog2(DEPTH+1)-1:0]   count_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH+1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_o       = mem_q[rd_ptr_q];
  assign count_o     = count_q;

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop && !push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

/* verilog/tl_macros.svh */
// **************************************************
// Widths fixed for single-beat 64-bit TL-UL traffic
// Source width after arbitration is host width + 1
// **************************************************
`ifndef TL_MACROS_SVH
`define TL_MACROS_SVH

// Byte address and data bus
`define TL_ADDR_W 32
`define TL_DATA_W 64
`define TL_MASK_W 8

// Source ids at a host port and on the shared bus
`define TL_HOST_SRC_W 3
`define TL_SRC_W 4

// IO window, bits set in the mask are don't care
`define IO_BASE 32'h8001_0000
`define IO_MASK 32'h0000_003f

// Word address at the BRAM port
`define BRAM_ADDR_W 29

`endif

/* verilog/tl_pkg.sv */
// **************************************************
// A and D channel payloads for TL-UL, no B/C/E
// **************************************************
`include "tl_macros.svh"

package tl_pkg;

  // A channel opcodes, TL-UL encoding
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Host ports leave the top source bit at zero
  typedef struct packed {
    tl_a_op_e                 opcode;
    logic [`TL_ADDR_W-1:0]    address;
    logic [`TL_MASK_W-1:0]    mask;
    logic [`TL_DATA_W-1:0]    data;
    logic [`TL_SRC_W-1:0]     source;
  } tl_a_t;

  typedef struct packed {
    tl_d_op_e                 opcode;
    logic [`TL_DATA_W-1:0]    data;
    logic [`TL_SRC_W-1:0]     source;
  } tl_d_t;

endpackage

/* verilog/tl_socket_1n.sv */
// **************************************************
// One IO window, everything else goes to memory
// D merge is round robin, no added latency
// **************************************************
`timescale 1ns/1ps
`include "tl_macros.svh"

module tl_socket_1n import tl_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_n_i,

  input  logic    host_a_valid_i,
  input  tl_a_t   host_a_i,
  output logic    host_a_ready_o,
  output logic    host_d_valid_o,
  output tl_d_t   host_d_o,
  input  logic    host_d_ready_i,

  output logic    mem_a_valid_o,
  output tl_a_t   mem_a_o,
  input  logic    mem_a_ready_i,
  input  logic    mem_d_valid_i,
  input  tl_d_t   mem_d_i,
  output logic    mem_d_ready_o,

  output logic    io_a_valid_o,
  output tl_a_t   io_a_o,
  input  logic    io_a_ready_i,
  input  logic    io_d_valid_i,
  input  tl_d_t   io_d_i,
  output logic    io_d_ready_o
);

  logic       is_io;
  logic [1:0] d_valid;
  logic       d_sel;
  logic       lock_q;
  logic       lock_sel_q;
  logic       prio_q;

  // Compare only the bits outside the window mask
  assign is_io = (((host_a_i.address ^ `IO_BASE) & ~`IO_MASK) == '0);

  assign mem_a_valid_o  = host_a_valid_i & ~is_io;
  assign io_a_valid_o   = host_a_valid_i & is_io;
  assign mem_a_o        = host_a_i;
  assign io_a_o         = host_a_i;
  assign host_a_ready_o = is_io ? io_a_ready_i : mem_a_ready_i;

  // Index 0 is memory, 1 is IO
  assign d_valid = {io_d_valid_i, mem_d_valid_i};

  always_comb
  begin
    if (lock_q)
    begin
      d_sel = lock_sel_q;
    end
    else if (&d_valid)
    begin
      d_sel = prio_q;
    end
    else
    begin
      d_sel = io_d_valid_i;
    end
  end

  assign host_d_valid_o = d_valid[d_sel];
  assign host_d_o       = d_sel ? io_d_i : mem_d_i;
  assign mem_d_ready_o  = host_d_ready_i & ~d_sel;
  assign io_d_ready_o   = host_d_ready_i & d_sel;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
      prio_q     <= 1'b0;
    end
    else if (host_d_valid_o)
    begin
      if (host_d_ready_i)
      begin
        lock_q <= 1'b0;
        prio_q <= ~d_sel;
      end
      else
      begin
        lock_q     <= 1'b1;
        lock_sel_q <= d_sel;
      end
    end
  end

endmodule
